//--- hw/fwft_fifo.sv
`timescale 1ns/1ps
`include "pcie_config.svh"

module fwft_fifo #(
   parameter type payload_t = logic,
   parameter int  depth     = `PCIE_FIFO_DEPTH,
   parameter int  min_room  = `PCIE_FIFO_ROOM
) (
   input  logic     clock,
   input  logic     reset,
   input  logic     push,
   input  payload_t push_data,
   output logic     room,       // at least min_room entries free
   input  logic     pop,
   output payload_t pop_data,   // head word, valid while not empty
   output logic     valid
);

   localparam int aw = (depth > 1) ? $clog2(depth) : 1;
   localparam int cw = $clog2(depth + 1);

   payload_t      mem [depth];
   logic [aw-1:0] wr_ptr;
   logic [aw-1:0] rd_ptr;
   logic [cw-1:0] count;
   logic          do_push;
   logic          do_pop;

   function automatic logic [aw-1:0] bump(input logic [aw-1:0] p);
      return (p == aw'(depth - 1)) ? '0 : p + 1'b1;
   endfunction

   assign do_pop   = pop && valid;
   assign do_push  = push && (count != cw'(depth));   // full FIFO refuses the word
   assign valid    = count != '0;
   assign room     = count <= cw'(depth - min_room);
   assign pop_data = mem[rd_ptr];

   always_ff @(posedge clock)
   begin
      if (reset)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         if (do_push)
            wr_ptr <= bump(wr_ptr);
         if (do_pop)
            rd_ptr <= bump(rd_ptr);
         case ({do_push, do_pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   always_ff @(posedge clock)
   begin
      if (do_push)
         mem[wr_ptr] <= push_data;
   end

endmodule

//--- hw/pcie_config.svh
`ifndef PCIE_CONFIG_SVH
`define PCIE_CONFIG_SVH

// fixed packet lengths in dwords
`define PCIE_RD_LEN_DW 128  // memory read request length
`define PCIE_WR_LEN_DW 32   // memory write payload, two dwords per data beat

// transmit FIFO in front of the core stream
`define PCIE_FIFO_DEPTH 32

// free entries needed before a new packet may start,
// equal to the longest packet (write, 18 words)
`define PCIE_FIFO_ROOM 18

`endif

//--- hw/pcie_req_pkg.sv
package pcie_req_pkg;

   // which request the arbiter hands to the formatter
   typedef enum logic [1:0] {
      req_none = 2'd0,
      req_cpl  = 2'd1,   // read completion
      req_rd   = 2'd2,   // memory read
      req_wr   = 2'd3    // memory write
   } req_kind_t;

   // read completion, two data dwords
   typedef struct packed {
      logic [31:0] dw2;    // completion header dword 2, passed through
      logic [63:0] data;
   } cpl_req_t;

   typedef struct packed {
      logic [63:0] addr;   // upper half zero selects the 3DW form
      logic [7:0]  tag;
   } rd_req_t;

   // data holds the current beat, replaced after each wr_ready
   typedef struct packed {
      logic [63:0] addr;
      logic [63:0] data;
   } wr_req_t;

endpackage

//--- hw/pcie_tlp_pkg.sv
package pcie_tlp_pkg;

   // completion with data, 2 DW, header dword 0
   localparam logic [31:0] cpl_hdr      = 32'h4A000002;
   localparam logic [15:0] cpl_byte_cnt = 16'd8;   // status zero, byte count 8

   // fmt field, bits [31:29] of header dword 0
   localparam logic [2:0] fmt_mrd_3dw = 3'b000;
   localparam logic [2:0] fmt_mrd_4dw = 3'b001;
   localparam logic [2:0] fmt_mwr_3dw = 3'b010;
   localparam logic [2:0] fmt_mwr_4dw = 3'b011;

   // last and first dword byte enables
   localparam logic [7:0] be_all = 8'hff;

   // one word of the core's transmit stream
   typedef struct packed {
      logic        one_dw;  // only the low dword is valid
      logic        last;    // final word of the packet
      logic [63:0] data;    // low dword goes out first
   } tx_word_t;

   // payload dwords go out in PCI Express byte order
   function automatic logic [31:0] swap_dw(input logic [31:0] x);
      return {x[7:0], x[15:8], x[23:16], x[31:24]};
   endfunction

   // header dword 0 for a memory request: fmt, type zero, length
   function automatic logic [31:0] mem_dw0(input logic [2:0] fmt, input logic [9:0] len);
      return {fmt, 19'd0, len};
   endfunction

endpackage

//--- hw/pcie_tx.sv
`timescale 1ns/1ps
`include "pcie_config.svh"

module pcie_tx (
   input  logic                    clock,
   input  logic                    reset,
   input  logic [15:0]             pcie_id,
   input  logic                    rc_done,
   input  pcie_req_pkg::cpl_req_t  cpl,
   input  logic                    rd_valid,
   input  pcie_req_pkg::rd_req_t   rd,
   output logic                    rd_ready,
   input  logic                    wr_valid,
   input  pcie_req_pkg::wr_req_t   wr,
   output logic                    wr_ready,
   input  logic                    tx_tready,
   output logic [63:0]             tx_tdata,
   output logic                    tx_tlast,
   output logic                    tx_1dw,
   output logic                    tx_tvalid
);

   pcie_req_pkg::req_kind_t grant;
   logic                    idle;
   logic                    room;
   logic                    push;
   pcie_tlp_pkg::tx_word_t  word;
   pcie_tlp_pkg::tx_word_t  head;   // FIFO output word

   tx_arbiter u_arbiter (
      .clock    (clock),
      .reset    (reset),
      .rc_done  (rc_done),
      .rd_valid (rd_valid),
      .wr_valid (wr_valid),
      .idle     (idle),
      .room     (room),
      .grant    (grant)
   );

   tlp_formatter u_formatter (
      .clock    (clock),
      .reset    (reset),
      .grant    (grant),
      .pcie_id  (pcie_id),
      .cpl      (cpl),
      .rd       (rd),
      .wr       (wr),
      .idle     (idle),
      .rd_ready (rd_ready),
      .wr_ready (wr_ready),
      .push     (push),
      .word     (word)
   );

   fwft_fifo #(
      .payload_t (pcie_tlp_pkg::tx_word_t),
      .depth     (`PCIE_FIFO_DEPTH)
   ) u_fifo (
      .clock     (clock),
      .reset     (reset),
      .push      (push),
      .push_data (word),
      .room      (room),
      .pop       (tx_tready),   // only takes effect with tx_tvalid
      .pop_data  (head),
      .valid     (tx_tvalid)
   );

   assign tx_tdata = head.data;
   assign tx_tlast = head.last;
   assign tx_1dw   = head.one_dw;

endmodule

//--- hw/tlp_formatter.sv
`timescale 1ns/1ps
`include "pcie_config.svh"

module tlp_formatter (
   input  logic                     clock,
   input  logic                     reset,
   input  pcie_req_pkg::req_kind_t  grant,
   input  logic [15:0]              pcie_id,
   input  pcie_req_pkg::cpl_req_t   cpl,
   input  pcie_req_pkg::rd_req_t    rd,
   input  pcie_req_pkg::wr_req_t    wr,
   output logic                     idle,
   output logic                     rd_ready,
   output logic                     wr_ready,
   output logic                     push,
   output pcie_tlp_pkg::tx_word_t   word
);

   localparam int         wr_beats = `PCIE_WR_LEN_DW / 2;
   localparam logic [4:0] cpl_last = 5'd2;
   localparam logic [4:0] rd_last  = 5'd1;
   localparam logic [4:0] wr_last  = 5'(wr_beats + 1);   // header, address, data beats
   localparam logic [9:0] rd_len   = 10'(`PCIE_RD_LEN_DW);
   localparam logic [9:0] wr_len   = 10'(`PCIE_WR_LEN_DW);

   pcie_req_pkg::req_kind_t kind_q;    // packet in progress after word 0
   pcie_req_pkg::req_kind_t cur_kind;
   logic [4:0]              idx_q;     // index of the next word to build
   logic [4:0]              cur_idx;
   logic [4:0]              last_idx;
   logic                    rd32;
   logic                    wr32;
   logic                    wr32_q;
   logic [63:0]             wr_data_q;  // previous write beat
   logic [31:0]             cur_lo_sw;
   logic [31:0]             prev_lo_sw;
   logic [31:0]             prev_hi_sw;
   pcie_tlp_pkg::tx_word_t  nxt;

   assign rd32 = rd.addr[63:32] == 32'd0;
   assign wr32 = wr.addr[63:32] == 32'd0;

   // word 0 is built in the grant cycle itself
   assign cur_kind = (kind_q == pcie_req_pkg::req_none) ? grant : kind_q;
   assign cur_idx  = (kind_q == pcie_req_pkg::req_none) ? 5'd0 : idx_q;

   always_comb
   begin
      case (cur_kind)
         pcie_req_pkg::req_cpl: last_idx = cpl_last;
         pcie_req_pkg::req_rd:  last_idx = rd_last;
         default:               last_idx = wr_last;
      endcase
   end

   // low until the last word has been pushed
   assign idle = (kind_q == pcie_req_pkg::req_none) && !push;

   // beat b is taken while word b+1 is built
   assign wr_ready = (kind_q == pcie_req_pkg::req_wr) && (idx_q <= 5'(wr_beats));

   assign cur_lo_sw  = pcie_tlp_pkg::swap_dw(wr.data[31:0]);
   assign prev_lo_sw = pcie_tlp_pkg::swap_dw(wr_data_q[31:0]);
   assign prev_hi_sw = pcie_tlp_pkg::swap_dw(wr_data_q[63:32]);

   always_comb
   begin
      nxt = '0;
      case (cur_kind)
         pcie_req_pkg::req_cpl:
         begin
            if (cur_idx == 5'd0)
               nxt.data = {pcie_id, pcie_tlp_pkg::cpl_byte_cnt, pcie_tlp_pkg::cpl_hdr};
            else if (cur_idx == 5'd1)
               nxt.data = {pcie_tlp_pkg::swap_dw(cpl.data[31:0]), cpl.dw2};
            else
            begin
               nxt.data   = {32'd0, pcie_tlp_pkg::swap_dw(cpl.data[63:32])};
               nxt.last   = 1'b1;
               nxt.one_dw = 1'b1;
            end
         end
         pcie_req_pkg::req_rd:
         begin
            if (cur_idx == 5'd0)
               nxt.data = {pcie_id, rd.tag, pcie_tlp_pkg::be_all,
                  pcie_tlp_pkg::mem_dw0(rd32 ? pcie_tlp_pkg::fmt_mrd_3dw
                                             : pcie_tlp_pkg::fmt_mrd_4dw, rd_len)};
            else
            begin
               nxt.last   = 1'b1;
               nxt.one_dw = rd32;
               nxt.data   = rd32 ? {32'd0, rd.addr[31:0]} : {rd.addr[31:0], rd.addr[63:32]};
            end
         end
         pcie_req_pkg::req_wr:
         begin
            if (cur_idx == 5'd0)
               nxt.data = {pcie_id, 8'd0, pcie_tlp_pkg::be_all,
                  pcie_tlp_pkg::mem_dw0(wr32 ? pcie_tlp_pkg::fmt_mwr_3dw
                                             : pcie_tlp_pkg::fmt_mwr_4dw, wr_len)};
            else if (cur_idx == 5'd1)
               nxt.data = wr32_q ? {cur_lo_sw, wr.addr[31:0]} : {wr.addr[31:0], wr.addr[63:32]};
            else if (wr32_q)
            begin
               // 3DW header shifts the data by one dword
               nxt.data   = (cur_idx == wr_last) ? {32'd0, prev_hi_sw} : {cur_lo_sw, prev_hi_sw};
               nxt.last   = cur_idx == wr_last;
               nxt.one_dw = cur_idx == wr_last;
            end
            else
            begin
               nxt.data = {prev_hi_sw, prev_lo_sw};
               nxt.last = cur_idx == wr_last;
            end
         end
         default:
            nxt = '0;
      endcase
   end

   always_ff @(posedge clock)
   begin
      if (reset)
      begin
         kind_q   <= pcie_req_pkg::req_none;
         idx_q    <= 5'd0;
         push     <= 1'b0;
         rd_ready <= 1'b0;
      end
      else
      begin
         push     <= cur_kind != pcie_req_pkg::req_none;
         rd_ready <= (cur_kind == pcie_req_pkg::req_rd) && (cur_idx == rd_last);
         if (cur_kind != pcie_req_pkg::req_none)
         begin
            if (cur_idx == last_idx)
            begin
               kind_q <= pcie_req_pkg::req_none;
               idx_q  <= 5'd0;
            end
            else
            begin
               kind_q <= cur_kind;
               idx_q  <= cur_idx + 5'd1;
            end
         end
      end
   end

   always_ff @(posedge clock)
   begin
      word      <= nxt;
      wr_data_q <= wr.data;
      if (cur_kind == pcie_req_pkg::req_wr && cur_idx == 5'd0)
         wr32_q <= wr32;   // address width fixed at the header
   end

endmodule

//--- hw/tx_arbiter.sv
`timescale 1ns/1ps

module tx_arbiter (
   input  logic                     clock,
   input  logic                     reset,
   input  logic                     rc_done,   // one-cycle completion strobe
   input  logic                     rd_valid,
   input  logic                     wr_valid,
   input  logic                     idle,      // formatter done with its packet
   input  logic                     room,      // FIFO can take a whole packet
   output pcie_req_pkg::req_kind_t  grant
);

   logic cpl_pend;   // completion seen but not yet granted
   logic can_grant;

   // a running packet keeps idle low, so a write is never interrupted
   assign can_grant = idle && room;

   // fixed priority, completion first
   always_comb
   begin
      grant = pcie_req_pkg::req_none;
      if (can_grant)
      begin
         if (cpl_pend)
            grant = pcie_req_pkg::req_cpl;
         else if (rd_valid)
            grant = pcie_req_pkg::req_rd;
         else if (wr_valid)
            grant = pcie_req_pkg::req_wr;
      end
   end

   always_ff @(posedge clock)
   begin
      if (reset)
         cpl_pend <= 1'b0;
      else if (rc_done)
         cpl_pend <= 1'b1;   // a new strobe wins over the clear
      else if (grant == pcie_req_pkg::req_cpl)
         cpl_pend <= 1'b0;
   end

endmodule

//--- tests/pcie_tx_tb.sv
`timescale 1ns/1ps
`include "pcie_config.svh"

module pcie_tx_tb;

   localparam int n_entries   = 9;
   localparam int cycle_limit = n_entries * 80 + 100;
   localparam int wr_beats    = `PCIE_WR_LEN_DW / 2;
   localparam int entry_wait  = 60;   // cycles allowed for one entry's words

   typedef struct packed {
      logic [1:0]  kind;    // 0 cpl, 1 read, 2 write, 3 all three at once
      logic [63:0] addr;
      logic [7:0]  tag;
      logic [31:0] dw2;
      logic [31:0] dseed;   // mixed into the data seed
      logic        bp;      // random tx_tready
   } entry_t;

   logic                   clock;
   logic                   reset;
   logic [15:0]            pcie_id;
   logic                   rc_done;
   pcie_req_pkg::cpl_req_t cpl;
   logic                   rd_valid;
   pcie_req_pkg::rd_req_t  rd;
   logic                   rd_ready;
   logic                   wr_valid;
   pcie_req_pkg::wr_req_t  wr;
   logic                   wr_ready;
   logic                   tx_tready;
   logic [63:0]            tx_tdata;
   logic                   tx_tlast;
   logic                   tx_1dw;
   logic                   tx_tvalid;

   entry_t      stim [n_entries];
   logic [63:0] beats [wr_beats];   // write data of the current entry
   logic [65:0] exp_q [$];          // {one_dw, last, data}
   logic [65:0] exp_w;
   integer      seed;
   int          errors;
   int          failed;
   int          cycles = 0;
   int          cur;
   int          nwords;
   int          rd_cnt;
   int          wr_cnt;
   logic        rd_hi;   // handshakes seen in the cycle just ended
   logic        wr_hi;

   pcie_tx DUT (
      .clock     (clock),
      .reset     (reset),
      .pcie_id   (pcie_id),
      .rc_done   (rc_done),
      .cpl       (cpl),
      .rd_valid  (rd_valid),
      .rd        (rd),
      .rd_ready  (rd_ready),
      .wr_valid  (wr_valid),
      .wr        (wr),
      .wr_ready  (wr_ready),
      .tx_tready (tx_tready),
      .tx_tdata  (tx_tdata),
      .tx_tlast  (tx_tlast),
      .tx_1dw    (tx_1dw),
      .tx_tvalid (tx_tvalid)
   );

   initial
   begin
      clock = 1'b0;
      forever #10 clock = ~clock;
   end

   always @(posedge clock)
   begin
      cycles = cycles + 1;
      if (cycles > cycle_limit)
      begin
         $display("timeout: run still going after %0d cycles", cycle_limit);
         $display("Done: errors found");
         $finish;
      end
   end

   // byte i of the result is byte 3-i of the dword
   function automatic logic [31:0] swap32(input logic [31:0] x);
      logic [31:0] y;
      for (int i = 0; i < 4; i++)
         y[8*i +: 8] = x[8*(3-i) +: 8];
      return y;
   endfunction

   function automatic string kind_name(input logic [1:0] k);
      case (k)
         2'd0:    return "completion";
         2'd1:    return "read";
         2'd2:    return "write";
         default: return "cpl+rd+wr";
      endcase
   endfunction

   task automatic compare(input string what, input logic [65:0] got, input logic [65:0] exp);
      if (got !== exp)
      begin
         $display("FAIL %0t: %s got %h expected %h", $time, what, got, exp);
         errors++;
      end
   endtask

   task automatic add_word(input logic [63:0] data, input logic last, input logic one);
      exp_q.push_back({one, last, data});
   endtask

   task automatic expect_cpl(input logic [31:0] dw2, input logic [63:0] data);
      add_word({pcie_id, 16'd8, 32'h4A000002}, 1'b0, 1'b0);
      add_word({swap32(data[31:0]), dw2}, 1'b0, 1'b0);
      add_word({32'd0, swap32(data[63:32])}, 1'b1, 1'b1);
   endtask

   task automatic expect_rd(input logic [63:0] addr, input logic [7:0] tag);
      logic is4;
      is4 = addr[63:32] != 32'd0;
      add_word({pcie_id, tag, 8'hff, 2'b00, is4, 19'd0, 10'(`PCIE_RD_LEN_DW)}, 1'b0, 1'b0);
      if (is4)
         add_word({addr[31:0], addr[63:32]}, 1'b1, 1'b0);
      else
         add_word({32'd0, addr[31:0]}, 1'b1, 1'b1);
   endtask

   task automatic expect_wr(input logic [63:0] addr);
      logic is4;
      int   k;
      is4 = addr[63:32] != 32'd0;
      add_word({pcie_id, 8'd0, 8'hff, 2'b01, is4, 19'd0, 10'(`PCIE_WR_LEN_DW)}, 1'b0, 1'b0);
      if (is4)
      begin
         add_word({addr[31:0], addr[63:32]}, 1'b0, 1'b0);
         for (k = 0; k < wr_beats; k++)
            add_word({swap32(beats[k][63:32]), swap32(beats[k][31:0])}, k == wr_beats - 1, 1'b0);
      end
      else
      begin
         // data shifted by one dword behind the 3DW header
         add_word({swap32(beats[0][31:0]), addr[31:0]}, 1'b0, 1'b0);
         for (k = 1; k < wr_beats; k++)
            add_word({swap32(beats[k][31:0]), swap32(beats[k - 1][63:32])}, 1'b0, 1'b0);
         add_word({32'd0, swap32(beats[wr_beats - 1][63:32])}, 1'b1, 1'b1);
      end
   endtask

   // stream monitor sampling mid-cycle
   always @(negedge clock)
   begin
      if (!reset)
      begin
         rd_hi  = rd_ready;
         wr_hi  = wr_ready;
         rd_cnt = rd_cnt + rd_ready;
         wr_cnt = wr_cnt + wr_ready;
         if (tx_tvalid && tx_tready)
         begin
            if (exp_q.size() == 0)
            begin
               $display("entry %0d: extra word %h came out of the DUT", cur, tx_tdata);
               errors++;
            end
            else
            begin
               exp_w = exp_q.pop_front();
               compare($sformatf("entry %0d word %0d", cur, nwords),
                  {tx_1dw, tx_tlast, tx_tdata}, exp_w);
               nwords++;
            end
         end
      end
   end

   task automatic run_entry(input int e);
      entry_t      s;
      logic [63:0] cdata;
      logic [63:0] wr_addr;
      logic [31:0] rnd;
      logic        has_cpl;
      logic        has_rd;
      logic        has_wr;
      int          nb;
      int          waited;
      int          err0;
      int          exp_words;
      s       = stim[e];
      has_cpl = (s.kind == 2'd0) || (s.kind == 2'd3);
      has_rd  = (s.kind == 2'd1) || (s.kind == 2'd3);
      has_wr  = (s.kind == 2'd2) || (s.kind == 2'd3);
      wr_addr = (s.kind == 2'd3) ? s.addr ^ 64'h100 : s.addr;
      err0    = errors;
      @(posedge clock);
      cur    = e;
      nwords = 0;
      rd_cnt = 0;
      wr_cnt = 0;
      seed   = seed ^ s.dseed;
      cdata[63:32] = $random(seed);
      cdata[31:0]  = $random(seed);
      for (nb = 0; nb < wr_beats; nb++)
      begin
         beats[nb][63:32] = $random(seed);
         beats[nb][31:0]  = $random(seed);
      end
      // packets leave in priority order
      if (has_cpl)
         expect_cpl(s.dw2, cdata);
      if (has_rd)
         expect_rd(s.addr, s.tag);
      if (has_wr)
         expect_wr(wr_addr);
      exp_words = exp_q.size();
      if (has_cpl)
      begin
         cpl     <= {s.dw2, cdata};
         rc_done <= 1'b1;
      end
      @(posedge clock);
      rc_done <= 1'b0;   // completion now pending when the others arrive
      if (has_rd)
      begin
         rd       <= {s.addr, s.tag};
         rd_valid <= 1'b1;
      end
      if (has_wr)
      begin
         wr       <= {wr_addr, beats[0]};
         wr_valid <= 1'b1;
      end
      nb     = 0;
      waited = 0;
      while (exp_q.size() != 0 && waited < entry_wait)
      begin
         @(posedge clock);
         rnd = $random(seed);
         tx_tready <= s.bp ? (rnd[1:0] != 2'b00) : 1'b1;
         if (rd_hi)
            rd_valid <= 1'b0;
         if (wr_hi)
         begin
            wr_valid <= 1'b0;   // write already granted
            nb++;
            if (nb < wr_beats)
               wr.data <= beats[nb];
         end
         waited++;
      end
      if (exp_q.size() != 0)
      begin
         $display("entry %0d: %0d expected words never came out", e, exp_q.size());
         errors++;
         exp_q.delete();
      end
      rd_valid  <= 1'b0;
      wr_valid  <= 1'b0;
      tx_tready <= 1'b1;
      repeat (8) @(posedge clock);   // room for stray words
      if (rd_cnt != (has_rd ? 1 : 0))
      begin
         $display("entry %0d: rd_ready was high for %0d cycles", e, rd_cnt);
         errors++;
      end
      if (wr_cnt != (has_wr ? wr_beats : 0))
      begin
         $display("entry %0d: wr_ready was high for %0d cycles, not %0d", e, wr_cnt,
            has_wr ? wr_beats : 0);
         errors++;
      end
      if (errors != err0)
         failed++;
      $display("entry %0d %s: %0d of %0d words, %s", e, kind_name(s.kind), nwords,
         exp_words, (errors == err0) ? "ok" : "failed");
   endtask

   initial
   begin
      seed      = 32'h45c3;
      reset     = 1'b1;
      pcie_id   = 16'h01a0;
      rc_done   = 1'b0;
      cpl       = '0;
      rd_valid  = 1'b0;
      rd        = '0;
      wr_valid  = 1'b0;
      wr        = '0;
      tx_tready = 1'b1;
      rd_hi     = 1'b0;
      wr_hi     = 1'b0;
      errors    = 0;
      failed    = 0;
      cur       = 0;
      nwords    = 0;
      rd_cnt    = 0;
      wr_cnt    = 0;
      // kind, addr, tag, dw2, dseed, bp
      stim[0] = {2'd0, 64'd0, 8'h00, 32'h0100_2a00, 32'h0000_0011, 1'b0};
      stim[1] = {2'd1, 64'h0000_0000_8000_1000, 8'h11, 32'd0, 32'h0000_0022, 1'b0};
      stim[2] = {2'd1, 64'h0000_0012_4000_0000, 8'h22, 32'd0, 32'h0000_0033, 1'b0};
      stim[3] = {2'd2, 64'h0000_0000_9000_0040, 8'h00, 32'd0, 32'h0000_0044, 1'b0};
      stim[4] = {2'd2, 64'h0000_0001_0000_0100, 8'h00, 32'd0, 32'h0000_0055, 1'b0};
      stim[5] = {2'd3, 64'h0000_0000_a000_0000, 8'h33, 32'h0200_1b00, 32'h0000_0066, 1'b0};
      stim[6] = {2'd2, 64'h0000_0000_9000_2000, 8'h00, 32'd0, 32'h0000_0077, 1'b1};
      stim[7] = {2'd3, 64'h0000_0003_0000_0800, 8'h44, 32'h0300_0c00, 32'h0000_0088, 1'b1};
      stim[8] = {2'd1, 64'h0000_00ff_0000_2000, 8'h55, 32'd0, 32'h0000_0099, 1'b1};
      repeat (4) @(posedge clock);
      reset <= 1'b0;
      @(negedge clock);
      compare("tx_tvalid after reset", tx_tvalid, 66'd0);
      compare("rd_ready and wr_ready after reset", {rd_ready, wr_ready}, 66'd0);
      for (int e = 0; e < n_entries; e++)
         run_entry(e);
      $display("%0d entries, %0d failed, %0d errors", n_entries, failed, errors);
      if (errors == 0)
         $display("Done: no errors");
      else
         $display("Done: errors found");
      $finish;
   end

endmodule

//--- vlog.f
+incdir+hw
hw/pcie_req_pkg.sv
hw/pcie_tlp_pkg.sv
hw/tx_arbiter.sv
hw/tlp_formatter.sv
hw/fwft_fifo.sv
hw/pcie_tx.sv
tests/pcie_tx_tb.sv
